// ==== src/llq_settings.svh ====
// Sizing defines for the linked-list queue manager
// Word width, context count and shared entry count

`ifndef LLQ_SETTINGS_SVH
`define LLQ_SETTINGS_SVH

// Width of one stored data word
`define LLQ_WORD_W 32

// Independent FIFO contexts sharing the pool
`define LLQ_CTXT_N 4

// Shared entries in the free pool
// Keep this a power of two so addr_t covers it exactly
`define LLQ_ENTRY_N 8

`endif

// ==== src/llq_pkg.sv ====
// Shared types for the linked-list queue manager
// Derived widths, per-queue state and sequencer states

package llq_pkg;

  `include "llq_settings.svh"

  // Datapath and index types
  typedef logic [`LLQ_WORD_W-1:0]          word_t;
  typedef logic [$clog2(`LLQ_CTXT_N)-1:0]  ctxt_t;
  typedef logic [$clog2(`LLQ_ENTRY_N)-1:0] addr_t;
  typedef logic [`LLQ_CTXT_N-1:0]          ctxt_vec_t;
  typedef logic [`LLQ_ENTRY_N-1:0]         entry_vec_t;

  // One queue, head and tail are only meaningful while not empty
  typedef struct packed {
    logic  empty;
    addr_t head;
    addr_t tail;
  } qstate_t;

  // One command walks through all four states
  typedef enum logic [1:0] {IDLE, LOOKUP, UPDATE, RESPOND} seq_state_t;

endpackage

// ==== src/llq_free_pool.sv ====
// Free pool allocation bitset
// Lowest-free search and pool-full flag

`timescale 1ns/100ps

`include "llq_settings.svh"

module llq_free_pool
(
  input  logic           clk,
  input  logic           arst_n,
  input  logic           alloc,
  input  logic           release_en,
  input  llq_pkg::addr_t release_addr,
  output llq_pkg::addr_t free_addr,
  output logic           pool_full
);

  import llq_pkg::*;

  // One bit per entry, set while the entry sits in a queue
  entry_vec_t used_r;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      used_r <= '0;
    else
    begin
      if (release_en)
        used_r[release_addr] <= 1'b0;
      if (alloc)
        used_r[free_addr] <= 1'b1;
    end
  end

  // Walk down so the lowest clear bit wins
  always_comb
  begin
    free_addr = '0;
    for (int i = `LLQ_ENTRY_N - 1; i >= 0; i--)
      if (!used_r[i])
        free_addr = addr_t'(i);
  end

  assign pool_full = &used_r;

endmodule

// ==== src/llq_state_table.sv ====
// Per-context queue state table
// Head, tail and empty flag per context, plus the empty vector

`timescale 1ns/100ps

`include "llq_settings.svh"

module llq_state_table
(
  input  logic               clk,
  input  logic               arst_n,
  input  llq_pkg::ctxt_t     state_ctxt,
  input  logic               state_we,
  input  llq_pkg::qstate_t   state_wr,
  output llq_pkg::qstate_t   cur_state,
  output llq_pkg::ctxt_vec_t queue_empty
);

  import llq_pkg::*;

  qstate_t q_r [`LLQ_CTXT_N];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // Every queue starts out empty
      for (int i = 0; i < `LLQ_CTXT_N; i++)
      begin
        q_r[i].empty <= 1'b1;
        q_r[i].head  <= '0;
        q_r[i].tail  <= '0;
      end
    end
    else if (state_we)
      q_r[state_ctxt] <= state_wr;
  end

  // Combinational read, same index as the write
  assign cur_state = q_r[state_ctxt];

  // Gather stored flags for the status port
  always_comb
  begin
    for (int i = 0; i < `LLQ_CTXT_N; i++)
      queue_empty[i] = q_r[i].empty;
  end

endmodule

// ==== src/llq_link_table.sv ====
// Next-pointer and data memories per entry
// Registered reads, single write port each

`timescale 1ns/100ps

`include "llq_settings.svh"

module llq_link_table
(
  input  logic           clk,
  input  llq_pkg::addr_t link_addr,
  input  logic           link_we,
  input  llq_pkg::addr_t link_wr_addr,
  input  llq_pkg::addr_t link_wr,
  input  logic           data_we,
  input  llq_pkg::word_t data_wr,
  output llq_pkg::addr_t link_rd,
  output llq_pkg::word_t data_rd
);

  import llq_pkg::*;

  addr_t next_mem [`LLQ_ENTRY_N];
  word_t data_mem [`LLQ_ENTRY_N];

  always_ff @(posedge clk)
  begin
    if (link_we)
      next_mem[link_wr_addr] <= link_wr;
    // Data always goes to the freshly allocated entry
    if (data_we)
      data_mem[link_wr] <= data_wr;
    // Both reads follow the head address one cycle later
    link_rd <= next_mem[link_addr];
    data_rd <= data_mem[link_addr];
  end

endmodule

// ==== src/llq_control.sv ====
// Command handshake and per-command sequencer
// Drives the state, free pool and link table strobes and the response

`timescale 1ns/100ps

module llq_control
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic            cmd_valid,
  input  logic            cmd_push,
  input  llq_pkg::ctxt_t  cmd_ctxt,
  input  llq_pkg::word_t  cmd_data,
  output logic            cmd_accept,
  input  llq_pkg::qstate_t cur_state,
  input  llq_pkg::addr_t  free_addr,
  input  logic            pool_full,
  input  llq_pkg::addr_t  link_rd,
  input  llq_pkg::word_t  data_rd,
  output llq_pkg::ctxt_t  state_ctxt,
  output logic            state_we,
  output llq_pkg::qstate_t state_wr,
  output logic            alloc,
  output logic            release_en,
  output llq_pkg::addr_t  release_addr,
  output llq_pkg::addr_t  link_addr,
  output logic            link_we,
  output llq_pkg::addr_t  link_wr_addr,
  output llq_pkg::addr_t  link_wr,
  output logic            data_we,
  output llq_pkg::word_t  data_wr,
  output logic            rsp_valid,
  output logic            rsp_push,
  output logic            rsp_empty,
  output llq_pkg::addr_t  rsp_addr,
  output llq_pkg::word_t  rsp_data
);

  import llq_pkg::*;

  // Sequencer and command control
  seq_state_t state_r;
  logic       run_r;
  logic       push_r;
  ctxt_t      ctxt_r;
  logic       empty_r;
  logic       rsp_valid_r;

  // Payload captured along the way
  word_t      data_r;
  addr_t      addr_r;
  qstate_t    st_r;

  logic       take;
  logic       in_update;

  // Held off only for a push into a full pool
  assign cmd_accept = run_r && (state_r == IDLE) && !(cmd_push && pool_full);
  assign take       = cmd_valid && cmd_accept;
  assign in_update  = (state_r == UPDATE);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_r     <= IDLE;
      run_r       <= 1'b0;
      push_r      <= 1'b0;
      ctxt_r      <= '0;
      empty_r     <= 1'b0;
      rsp_valid_r <= 1'b0;
    end
    else
    begin
      // First edge out of reset opens the command port
      run_r       <= 1'b1;
      rsp_valid_r <= (state_r == RESPOND);
      case (state_r)
        IDLE:
        begin
          if (take)
          begin
            state_r <= LOOKUP;
            push_r  <= cmd_push;
            ctxt_r  <= cmd_ctxt;
          end
        end
        LOOKUP:
        begin
          state_r <= UPDATE;
          // Only a pop can see an empty queue
          empty_r <= !push_r && cur_state.empty;
        end
        UPDATE:  state_r <= RESPOND;
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
      data_r <= cmd_data;
    // Snapshot queue state and pick the entry this command works on
    if (state_r == LOOKUP)
    begin
      st_r <= cur_state;
      if (push_r)
        addr_r <= free_addr;
      else if (cur_state.empty)
        addr_r <= '0;
      else
        addr_r <= cur_state.head;
    end
    // Pop picks up the head word from the registered read
    if (in_update && !push_r)
      data_r <= st_r.empty ? '0 : data_rd;
  end

  // Table reads follow the registered context
  assign state_ctxt = ctxt_r;
  assign link_addr  = cur_state.head;

  // All writes land on the closing edge of UPDATE
  assign alloc        = in_update && push_r;
  assign release_en   = in_update && !push_r && !st_r.empty;
  assign release_addr = st_r.head;
  assign state_we     = alloc || release_en;

  assign data_we      = alloc;
  assign data_wr      = data_r;
  // Chain the new entry after the old tail
  assign link_we      = alloc && !st_r.empty;
  assign link_wr_addr = st_r.tail;
  assign link_wr      = addr_r;

  always_comb
  begin
    state_wr = st_r;
    if (push_r)
    begin
      state_wr.empty = 1'b0;
      // New entry becomes head too when the queue was empty
      state_wr.head  = st_r.empty ? addr_r : st_r.head;
      state_wr.tail  = addr_r;
    end
    else if (st_r.head == st_r.tail)
      state_wr.empty = 1'b1;
    else
      state_wr.head = link_rd;
  end

  // Response straight from registers
  assign rsp_valid = rsp_valid_r;
  assign rsp_push  = push_r;
  assign rsp_empty = empty_r;
  assign rsp_addr  = addr_r;
  assign rsp_data  = data_r;

endmodule

// ==== src/llq_top.sv ====
// Linked-list queue manager top level
// Sequencer plus free pool, state table and link table

`timescale 1ns/100ps

module llq_top
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               cmd_valid,
  input  logic               cmd_push,
  input  llq_pkg::ctxt_t     cmd_ctxt,
  input  llq_pkg::word_t     cmd_data,
  output logic               cmd_accept,
  output logic               rsp_valid,
  output logic               rsp_push,
  output logic               rsp_empty,
  output llq_pkg::addr_t     rsp_addr,
  output llq_pkg::word_t     rsp_data,
  output llq_pkg::ctxt_vec_t queue_empty,
  output logic               pool_full
);

  import llq_pkg::*;

  // State table port
  qstate_t cur_state;
  ctxt_t   state_ctxt;
  logic    state_we;
  qstate_t state_wr;

  // Free pool port
  addr_t   free_addr;
  logic    alloc;
  logic    release_en;
  addr_t   release_addr;

  // Link and data memories
  addr_t   link_addr;
  logic    link_we;
  addr_t   link_wr_addr;
  addr_t   link_wr;
  logic    data_we;
  word_t   data_wr;
  addr_t   link_rd;
  word_t   data_rd;

  llq_control u_control
  (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_valid    (cmd_valid),
    .cmd_push     (cmd_push),
    .cmd_ctxt     (cmd_ctxt),
    .cmd_data     (cmd_data),
    .cmd_accept   (cmd_accept),
    .cur_state    (cur_state),
    .free_addr    (free_addr),
    .pool_full    (pool_full),
    .link_rd      (link_rd),
    .data_rd      (data_rd),
    .state_ctxt   (state_ctxt),
    .state_we     (state_we),
    .state_wr     (state_wr),
    .alloc        (alloc),
    .release_en   (release_en),
    .release_addr (release_addr),
    .link_addr    (link_addr),
    .link_we      (link_we),
    .link_wr_addr (link_wr_addr),
    .link_wr      (link_wr),
    .data_we      (data_we),
    .data_wr      (data_wr),
    .rsp_valid    (rsp_valid),
    .rsp_push     (rsp_push),
    .rsp_empty    (rsp_empty),
    .rsp_addr     (rsp_addr),
    .rsp_data     (rsp_data)
  );

  llq_free_pool u_free_pool
  (
    .clk          (clk),
    .arst_n       (arst_n),
    .alloc        (alloc),
    .release_en   (release_en),
    .release_addr (release_addr),
    .free_addr    (free_addr),
    .pool_full    (pool_full)
  );

  llq_state_table u_state_table
  (
    .clk         (clk),
    .arst_n      (arst_n),
    .state_ctxt  (state_ctxt),
    .state_we    (state_we),
    .state_wr    (state_wr),
    .cur_state   (cur_state),
    .queue_empty (queue_empty)
  );

  llq_link_table u_link_table
  (
    .clk          (clk),
    .link_addr    (link_addr),
    .link_we      (link_we),
    .link_wr_addr (link_wr_addr),
    .link_wr      (link_wr),
    .data_we      (data_we),
    .data_wr      (data_wr),
    .link_rd      (link_rd),
    .data_rd      (data_rd)
  );

endmodule

// ==== tb/llq_tb.sv ====
// Testbench for the linked-list queue manager
// Directed tests with model queues, a free-set model, checker and timeout

`timescale 1ns/100ps

`include "llq_settings.svh"

module llq_tb;

  import llq_pkg::*;

  localparam int SEED           = 73039;
  localparam int TIMEOUT_CYCLES = 2000;

  logic      clk;
  logic      arst_n;
  logic      cmd_valid;
  logic      cmd_push;
  ctxt_t     cmd_ctxt;
  word_t     cmd_data;
  logic      cmd_accept;
  logic      rsp_valid;
  logic      rsp_push;
  logic      rsp_empty;
  addr_t     rsp_addr;
  word_t     rsp_data;
  ctxt_vec_t queue_empty;
  logic      pool_full;

  // One model FIFO ring buffer per context
  word_t      m_word [`LLQ_CTXT_N][`LLQ_ENTRY_N];
  addr_t      m_addr [`LLQ_CTXT_N][`LLQ_ENTRY_N];
  int         m_head [`LLQ_CTXT_N];
  int         m_cnt  [`LLQ_CTXT_N];
  // Entries the model believes are taken
  entry_vec_t m_used;

  int         cycle_cnt;

  llq_top dut
  (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_valid   (cmd_valid),
    .cmd_push    (cmd_push),
    .cmd_ctxt    (cmd_ctxt),
    .cmd_data    (cmd_data),
    .cmd_accept  (cmd_accept),
    .rsp_valid   (rsp_valid),
    .rsp_push    (rsp_push),
    .rsp_empty   (rsp_empty),
    .rsp_addr    (rsp_addr),
    .rsp_data    (rsp_data),
    .queue_empty (queue_empty),
    .pool_full   (pool_full)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Hard stop if anything stalls
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: no progress after %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // First clear bit scanning upward from entry 0
  function automatic addr_t lowest_free();
    addr_t a;
    logic  found;
    a     = '0;
    found = 1'b0;
    for (int i = 0; i < `LLQ_ENTRY_N; i++)
    begin
      if (!found && !m_used[i])
      begin
        a     = addr_t'(i);
        found = 1'b1;
      end
    end
    return a;
  endfunction

  function automatic ctxt_vec_t model_empty();
    ctxt_vec_t v;
    for (int i = 0; i < `LLQ_CTXT_N; i++)
      v[i] = (m_cnt[i] == 0);
    return v;
  endfunction

  task automatic compare_status();
    check("queue_empty", 32'(queue_empty), 32'(model_empty()));
    check("pool_full", 32'(pool_full), 32'(&m_used));
  endtask

  // Offer one command and wait for accept and the response pulse
  task automatic do_cmd(input logic push, input ctxt_t c, input word_t w);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_push  <= push;
    cmd_ctxt  <= c;
    cmd_data  <= w;
    // Sample mid-cycle since transfer happens on the following edge
    @(negedge clk);
    while (!cmd_accept)
      @(negedge clk);
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk);
    while (!rsp_valid)
      @(negedge clk);
  endtask

  task automatic push_word(input ctxt_t c, input word_t w);
    addr_t exp_addr;
    int    slot;
    exp_addr = lowest_free();
    do_cmd(1'b1, c, w);
    check("rsp_push", 32'(rsp_push), 32'd1);
    check("rsp_empty", 32'(rsp_empty), 32'd0);
    check("rsp_addr", 32'(rsp_addr), 32'(exp_addr));
    check("rsp_data", rsp_data, w);
    // Append to the model tail
    slot = (m_head[c] + m_cnt[c]) % `LLQ_ENTRY_N;
    m_word[c][slot]  = w;
    m_addr[c][slot]  = exp_addr;
    m_cnt[c]         = m_cnt[c] + 1;
    m_used[exp_addr] = 1'b1;
    compare_status();
  endtask

  task automatic pop_word(input ctxt_t c);
    logic  exp_empty;
    word_t exp_word;
    addr_t exp_addr;
    exp_empty = (m_cnt[c] == 0);
    exp_word  = '0;
    exp_addr  = '0;
    if (!exp_empty)
    begin
      exp_word = m_word[c][m_head[c]];
      exp_addr = m_addr[c][m_head[c]];
    end
    do_cmd(1'b0, c, '0);
    check("rsp_push", 32'(rsp_push), 32'd0);
    check("rsp_empty", 32'(rsp_empty), 32'(exp_empty));
    check("rsp_addr", 32'(rsp_addr), 32'(exp_addr));
    check("rsp_data", rsp_data, exp_word);
    if (!exp_empty)
    begin
      m_head[c]        = (m_head[c] + 1) % `LLQ_ENTRY_N;
      m_cnt[c]         = m_cnt[c] - 1;
      m_used[exp_addr] = 1'b0;
    end
    compare_status();
  endtask

  task automatic drain_all();
    for (int c = 0; c < `LLQ_CTXT_N; c++)
      while (m_cnt[c] > 0)
        pop_word(ctxt_t'(c));
  endtask

  // Push offered against a full pool and then withdrawn
  task automatic hold_push_blocked(input ctxt_t c, input word_t w, input int n);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_push  <= 1'b1;
    cmd_ctxt  <= c;
    cmd_data  <= w;
    repeat (n)
    begin
      @(negedge clk);
      check("cmd_accept", 32'(cmd_accept), 32'd0);
    end
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic reset_defaults();
    // Port stays closed while reset is held
    repeat (4)
    begin
      @(negedge clk);
      check("cmd_accept", 32'(cmd_accept), 32'd0);
    end
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check("queue_empty", 32'(queue_empty), 32'hf);
    check("pool_full", 32'(pool_full), 32'd0);
    check("rsp_valid", 32'(rsp_valid), 32'd0);
  endtask

  task automatic single_ctxt_order();
    for (int i = 0; i < 5; i++)
      push_word(2'd2, word_t'($urandom));
    for (int i = 0; i < 5; i++)
      pop_word(2'd2);
  endtask

  task automatic ctxt_independence();
    ctxt_t c;
    for (int i = 0; i < 20; i++)
    begin
      c = ctxt_t'($urandom_range(3, 0));
      // Random mix of pushes and pops with a forced pop while the pool is full
      if ((m_cnt[c] != 0 && $urandom_range(1, 0) == 1) || (&m_used))
        pop_word(c);
      else
        push_word(c, word_t'($urandom));
    end
    drain_all();
  endtask

  task automatic full_pool_stall();
    word_t w;
    addr_t freed;
    for (int i = 0; i < `LLQ_ENTRY_N; i++)
      push_word(ctxt_t'(i % `LLQ_CTXT_N), word_t'($urandom));
    check("pool_full", 32'(pool_full), 32'd1);
    w = word_t'($urandom);
    hold_push_blocked(2'd1, w, 10);
    // Head of context 1 is the entry the pop gives back
    freed = m_addr[1][m_head[1]];
    pop_word(2'd1);
    check("pool_full", 32'(pool_full), 32'd0);
    // Retried push lands in the slot just released
    push_word(2'd1, w);
    check("rsp_addr", 32'(rsp_addr), 32'(freed));
    drain_all();
  endtask

  task automatic empty_ctxt_pop();
    push_word(2'd2, word_t'($urandom));
    pop_word(2'd3);
    pop_word(2'd0);
    // Only context 2 holds an entry
    check("queue_empty", 32'(queue_empty), 32'hb);
    check("pool_full", 32'(pool_full), 32'd0);
    drain_all();
  endtask

  task automatic freed_addr_reuse();
    addr_t exp_reuse [4];
    exp_reuse[0] = 3'd0;
    exp_reuse[1] = 3'd1;
    exp_reuse[2] = 3'd2;
    exp_reuse[3] = 3'd4;
    // Entries 0..7 spread round robin over contexts 0..2
    for (int i = 0; i < `LLQ_ENTRY_N; i++)
      push_word(ctxt_t'(i % 3), word_t'($urandom));
    // Frees 1, 2, 4 and 0 in that order
    pop_word(2'd1);
    pop_word(2'd2);
    pop_word(2'd1);
    pop_word(2'd0);
    for (int i = 0; i < 4; i++)
    begin
      push_word(2'd3, word_t'($urandom));
      check("rsp_addr", 32'(rsp_addr), 32'(exp_reuse[i]));
    end
    drain_all();
  endtask

  initial
  begin
    void'($urandom(SEED));
    cycle_cnt = 0;
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd_push  = 1'b0;
    cmd_ctxt  = '0;
    cmd_data  = '0;
    m_used    = '0;
    for (int i = 0; i < `LLQ_CTXT_N; i++)
    begin
      m_head[i] = 0;
      m_cnt[i]  = 0;
    end

    reset_defaults();
    single_ctxt_order();
    ctxt_independence();
    full_pool_stall();
    empty_ctxt_pop();
    freed_addr_reuse();

    $display("Test passed");
    $finish;
  end

endmodule

// ==== llq_top.f ====
+incdir+src
src/llq_pkg.sv
src/llq_free_pool.sv
src/llq_state_table.sv
src/llq_link_table.sv
src/llq_control.sv
src/llq_top.sv
tb/llq_tb.sv

// ==== Makefile ====
# Verilator build and run for the linked-list queue manager

VERILATOR ?= verilator
TOP       ?= llq_tb
FILELIST  ?= llq_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
